//--- hdl/alu.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module alu (
  input  rv_pkg::alu_op_e     op,
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_pkg::br_cond_e    cond,
  input  logic [`RV_XLEN-1:0] cmp_a,
  input  logic [`RV_XLEN-1:0] cmp_b,
  output logic [`RV_XLEN-1:0] result,
  output logic                taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       cmp_eq;
  logic       cmp_lt;   // Signed
  logic       cmp_ltu;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;  // Also load/store/JALR addresses
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, a < b};
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch compare always on the two register operands
  assign cmp_eq  = (cmp_a == cmp_b);
  assign cmp_lt  = ($signed(cmp_a) < $signed(cmp_b));
  assign cmp_ltu = (cmp_a < cmp_b);

  always_comb begin
    case (cond)
      BR_EQ:   taken = cmp_eq;
      BR_NE:   taken = !cmp_eq;
      BR_LT:   taken = cmp_lt;
      BR_GE:   taken = !cmp_lt;
      BR_LTU:  taken = cmp_ltu;
      BR_GEU:  taken = !cmp_ltu;
      default: taken = 1'b0;
    endcase
  end

endmodule

//--- hdl/insn_decode.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module insn_decode (
  input  logic [`RV_XLEN-1:0]       insn,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_REG_ADDR_W-1:0] rd,
  output logic [`RV_XLEN-1:0]       imm,
  output rv_pkg::alu_op_e           alu_op,
  output logic                      alu_src_imm,
  output logic                      alu_src_pc,
  output rv_pkg::br_cond_e          br_cond,
  output rv_pkg::pc_sel_e           pc_sel,
  output logic                      rf_we,
  output logic                      mem_read,
  output logic                      mem_write,
  output logic                      is_ecall
);
  import rv_pkg::*;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;
  logic                imm_ok;  // funct7 legal for OP_IMM
  logic                rr_ok;   // funct7 legal for OP

  // Shared funct3 map, alt picks SUB or SRA
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  // Sign-extended immediates per format
  assign imm_i = {{(`RV_XLEN-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(`RV_XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(`RV_XLEN-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-21){insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0) :
                  (funct3 == 3'b101) ? (funct7 == 7'b0 || funct7 == 7'b0100000) : 1'b1;
  assign rr_ok  = (funct7 == 7'b0) ||
                  (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  always_comb begin
    // Anything not matched below retires as a no-op
    imm         = imm_i;
    alu_op      = ALU_ADD;
    alu_src_imm = 1'b0;
    alu_src_pc  = 1'b0;
    br_cond     = BR_EQ;
    pc_sel      = PC_SEQ;
    rf_we       = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_ecall    = 1'b0;
    case (opcode)
      OPC_LUI: begin
        imm         = imm_u;
        alu_op      = ALU_PASS_B;
        alu_src_imm = 1'b1;
        rf_we       = 1'b1;
      end
      OPC_AUIPC: begin
        imm         = imm_u;
        alu_src_imm = 1'b1;
        alu_src_pc  = 1'b1;
        rf_we       = 1'b1;
      end
      OPC_JAL: begin
        imm    = imm_j;
        pc_sel = PC_JAL;
        rf_we  = 1'b1;  // Link value picked in the top
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          alu_src_imm = 1'b1;  // Target is rs1 + imm_i
          pc_sel      = PC_JALR;
          rf_we       = 1'b1;
        end
      end
      OPC_BRANCH: begin
        imm = imm_b;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin
          br_cond = br_cond_e'(funct3);
          pc_sel  = PC_BRANCH;
        end
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin  // LW only
          alu_src_imm = 1'b1;
          mem_read    = 1'b1;
          rf_we       = 1'b1;
        end
      end
      OPC_STORE: begin
        imm = imm_s;
        if (funct3 == 3'b010) begin  // SW only
          alu_src_imm = 1'b1;
          mem_write   = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        alu_op      = arith_op(funct3, funct3 == 3'b101 && insn[30]);
        alu_src_imm = 1'b1;
        rf_we       = imm_ok;
      end
      OPC_OP: begin
        alu_op = arith_op(funct3, insn[30]);
        rf_we  = rr_ok;
      end
      OPC_SYSTEM: is_ecall = (insn[31:7] == '0);  // EBREAK, CSR ops ignored
      default: ;  // FENCE and undefined opcodes
    endcase
  end

endmodule

//--- hdl/pc_unit.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module pc_unit (
  input  logic                clk,
  input  logic                rst,
  input  rv_pkg::pc_sel_e     pc_sel,
  input  logic                taken,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] jalr_target,
  input  logic                is_ecall,
  output logic [`RV_XLEN-1:0] pc,
  output logic [`RV_XLEN-1:0] pc_plus4,
  output logic                halt,
  output logic                commit
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] pc_rel;  // Branch and JAL target
  logic [`RV_XLEN-1:0] next_pc;

  assign pc_plus4 = pc + `RV_INSN_BYTES;
  assign pc_rel   = pc + imm;

  always_comb begin
    case (pc_sel)
      PC_BRANCH: next_pc = taken ? pc_rel : pc_plus4;
      PC_JAL:    next_pc = pc_rel;
      PC_JALR:   next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0};
      default:   next_pc = pc_plus4;
    endcase
  end

  // ECALL freezes the PC on itself, sticky until reset
  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else if (!halt) begin
      if (is_ecall) begin
        halt <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  assign commit = !rst && !halt;

  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  ) else $error("pc_unit: misaligned PC %h", pc);

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      we,
  input  logic [`RV_REG_ADDR_W-1:0] rd,
  input  logic [`RV_XLEN-1:0]       rd_data,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       rs1_data,
  output logic [`RV_XLEN-1:0]       rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin  // Writes to x0 dropped
      regs[rd] <= rd_data;
    end
  end

  // Combinational read ports
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // x0 reads as zero whatever was written before
  a_x0_reads_zero: assert property (
    @(posedge clk) (rs1 == '0) |-> (rs1_data == '0)
  ) else $error("reg_file: x0 read back nonzero %h", rs1_data);

endmodule

//--- hdl/riscv_core.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module riscv_core (
  input  logic                clk,
  input  logic                rst,
  output logic [`RV_XLEN-1:0] imem_addr,
  input  logic [`RV_XLEN-1:0] imem_data,
  output logic [`RV_XLEN-1:0] dmem_addr,
  output logic [`RV_XLEN-1:0] dmem_wdata,
  output logic                dmem_we,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic                halt
);
  import rv_pkg::*;

  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_XLEN-1:0]       imm;
  alu_op_e                   alu_op;
  logic                      alu_src_imm;
  logic                      alu_src_pc;
  br_cond_e                  br_cond;
  pc_sel_e                   pc_sel;
  logic                      rf_we;
  logic                      mem_read;
  logic                      mem_write;
  logic                      is_ecall;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;
  logic [`RV_XLEN-1:0]       alu_a;
  logic [`RV_XLEN-1:0]       alu_b;
  logic [`RV_XLEN-1:0]       alu_result;
  logic                      taken;
  logic [`RV_XLEN-1:0]       pc;
  logic [`RV_XLEN-1:0]       pc_plus4;
  logic                      commit;
  logic [`RV_XLEN-1:0]       wb_data;

  insn_decode u_decode (
    .insn(imem_data), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .alu_src_imm(alu_src_imm), .alu_src_pc(alu_src_pc),
    .br_cond(br_cond), .pc_sel(pc_sel), .rf_we(rf_we),
    .mem_read(mem_read), .mem_write(mem_write), .is_ecall(is_ecall)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .we(rf_we && commit), .rd(rd), .rd_data(wb_data),
    .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_a = alu_src_pc  ? pc  : rs1_data;  // AUIPC
  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu u_alu (
    .op(alu_op), .a(alu_a), .b(alu_b), .cond(br_cond),
    .cmp_a(rs1_data), .cmp_b(rs2_data), .result(alu_result), .taken(taken)
  );

  pc_unit u_pc (
    .clk(clk), .rst(rst), .pc_sel(pc_sel), .taken(taken), .imm(imm),
    .jalr_target(alu_result), .is_ecall(is_ecall),
    .pc(pc), .pc_plus4(pc_plus4), .halt(halt), .commit(commit)
  );

  // Writeback source
  always_comb begin
    if (mem_read) begin
      wb_data = dmem_rdata;
    end else if (pc_sel == PC_JAL || pc_sel == PC_JALR) begin
      wb_data = pc_plus4;  // Link address
    end else begin
      wb_data = alu_result;
    end
  end

  assign imem_addr  = pc;
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = mem_write && commit;

  // Only SW reaches memory, so every store is word aligned
  a_store_aligned: assert property (
    @(posedge clk) dmem_we |-> (dmem_addr[1:0] == 2'b00)
  ) else $error("riscv_core: unaligned store to %h", dmem_addr);

endmodule

//--- hdl/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Datapath and register file geometry
`define RV_XLEN        32
`define RV_NUM_REGS    32
`define RV_REG_ADDR_W  5

// Fetch starts here after reset
`define RV_RESET_PC    32'h0000_0000

// Sequential PC step
`define RV_INSN_BYTES  32'd4

`endif

//--- hdl/rv_pkg.sv
package rv_pkg;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b00_000_11,
    OPC_STORE    = 7'b01_000_11,
    OPC_BRANCH   = 7'b11_000_11,
    OPC_JALR     = 7'b11_001_11,
    OPC_MISC_MEM = 7'b00_011_11,
    OPC_JAL      = 7'b11_011_11,
    OPC_OP_IMM   = 7'b00_100_11,
    OPC_OP       = 7'b01_100_11,
    OPC_SYSTEM   = 7'b11_100_11,
    OPC_AUIPC    = 7'b00_101_11,
    OPC_LUI      = 7'b01_101_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  // Same values as the branch funct3 field
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } br_cond_e;

  typedef enum logic [1:0] {
    PC_SEQ,
    PC_BRANCH,
    PC_JAL,
    PC_JALR
  } pc_sel_e;

endpackage

//--- riscv_core.f
+incdir+hdl
+incdir+test
hdl/rv_pkg.sv
hdl/reg_file.sv
hdl/insn_decode.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/riscv_core.sv
test/tb_riscv_core.sv

//--- test/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Word k is fetched from byte address 4*k
localparam int PROG_WORDS = 99;
localparam logic [31:0] PROG_IMAGE [PROG_WORDS] = '{
  imm_op(0, 1, 0, 5), imm_op(0, 2, 0, -3), lui(3, 'h80000), sw(3, 'h100),  // x1=5 x2=-3
  auipc(4, 1), sw(4, 'h104),
  imm_op(2, 5, 2, -1), sw(5, 'h108), imm_op(3, 5, 2, 6), sw(5, 'h10C),  // SLTI SLTIU
  imm_op(4, 5, 2, 'hF0), sw(5, 'h110), imm_op(6, 5, 1, 'h700), sw(5, 'h114),
  imm_op(7, 5, 2, 'hFF), sw(5, 'h118), imm_op(1, 5, 1, 28), sw(5, 'h11C),
  imm_op(5, 5, 2, 4), sw(5, 'h120), imm_op(5, 5, 2, 'h401), sw(5, 'h124),  // SRLI SRAI
  imm_op(0, 5, 2, -2045), sw(5, 'h128),
  reg_op(0, 0, 6, 1, 2), sw(6, 'h12C), reg_op('h20, 0, 6, 1, 2), sw(6, 'h130),
  reg_op(0, 1, 6, 2, 1), sw(6, 'h134), reg_op(0, 2, 6, 2, 1), sw(6, 'h138),
  reg_op(0, 3, 6, 2, 1), sw(6, 'h13C), reg_op(0, 4, 6, 1, 2), sw(6, 'h140),
  reg_op(0, 5, 6, 3, 1), sw(6, 'h144), reg_op('h20, 5, 6, 3, 1), sw(6, 'h148),  // SRL SRA
  reg_op(0, 6, 6, 1, 3), sw(6, 'h14C), reg_op(0, 7, 6, 2, 1), sw(6, 'h150),
  imm_op(0, 7, 0, 5),
  // Each condition taken over a stray store, then not taken into a real one
  branch(0, 1, 7, 8), sw(0, 'h1FC), branch(0, 1, 2, 8), sw(1, 'h154),
  branch(1, 1, 2, 8), sw(0, 'h1FC), branch(1, 1, 7, 8), sw(1, 'h158),
  branch(4, 2, 1, 8), sw(0, 'h1FC), branch(4, 1, 2, 8), sw(1, 'h15C),
  branch(5, 1, 2, 8), sw(0, 'h1FC), branch(5, 2, 1, 8), sw(1, 'h160),
  branch(6, 1, 2, 8), sw(0, 'h1FC), branch(6, 2, 1, 8), sw(1, 'h164),
  branch(7, 2, 1, 8), sw(0, 'h1FC), branch(7, 1, 2, 8), sw(1, 'h168),
  jal(8, 8), sw(0, 'h1FC), sw(8, 'h16C),
  imm_op(0, 9, 0, 'h12C), jalr(10, 9, 5), sw(0, 'h1FC), sw(0, 'h1FC), sw(10, 'h170),
  imm_op(0, 0, 0, 123), sw(0, 'h174),  // x0 stays zero
  32'hFFFF_FFFF, reg_op(1, 0, 1, 1, 2), 32'h0FF0_000F, sw(1, 'h178),  // Bad op, MUL, FENCE
  lw(11, 'h380), lw(12, 'h384), lw(13, 'h388), lw(14, 'h38C),
  reg_op(0, 0, 15, 11, 12), sw(15, 'h17C), reg_op('h20, 0, 15, 11, 13), sw(15, 'h180),
  reg_op(0, 4, 15, 12, 14), sw(15, 'h184), reg_op('h20, 5, 15, 13, 14), sw(15, 'h188),
  reg_op(0, 3, 15, 11, 14), sw(15, 'h18C), sw(14, 'h190), ECALL
};

// Stores that do not depend on the random words, {address, data}
localparam int STORE_LOG_LEN = 31;
localparam logic [63:0] STORE_LOG [STORE_LOG_LEN] = '{
  {32'h100, 32'h8000_0000}, {32'h104, 32'h0000_1010}, {32'h108, 32'h0000_0001},
  {32'h10C, 32'h0000_0000}, {32'h110, 32'hFFFF_FF0D}, {32'h114, 32'h0000_0705},
  {32'h118, 32'h0000_00FD}, {32'h11C, 32'h5000_0000}, {32'h120, 32'h0FFF_FFFF},
  {32'h124, 32'hFFFF_FFFE}, {32'h128, 32'hFFFF_F800}, {32'h12C, 32'h0000_0002},
  {32'h130, 32'h0000_0008}, {32'h134, 32'hFFFF_FFA0}, {32'h138, 32'h0000_0001},
  {32'h13C, 32'h0000_0000}, {32'h140, 32'hFFFF_FFF8}, {32'h144, 32'h0400_0000},
  {32'h148, 32'hFC00_0000}, {32'h14C, 32'h8000_0005}, {32'h150, 32'h0000_0005},
  {32'h154, 32'h0000_0005}, {32'h158, 32'h0000_0005}, {32'h15C, 32'h0000_0005},
  {32'h160, 32'h0000_0005}, {32'h164, 32'h0000_0005}, {32'h168, 32'h0000_0005},
  {32'h16C, 32'h0000_0118}, {32'h170, 32'h0000_0128}, {32'h174, 32'h0000_0000},
  {32'h178, 32'h0000_0005}
};

`endif

//--- test/tb_riscv_core.sv
`timescale 1ns/1ns
`include "rv_cfg.svh"

module tb_riscv_core;

  localparam int HALT_TIMEOUT = 500;  // Cycles
  localparam int IMEM_WORDS = 128;
  localparam int DMEM_WORDS = 256;
  localparam int RAND_INDEX = 'h380 / 4;  // Random input words live here
  localparam logic [31:0] ECALL = 32'h0000_0073;

  logic                clk;
  logic                rst;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [`RV_XLEN-1:0] imem_data;
  logic [`RV_XLEN-1:0] dmem_addr;
  logic [`RV_XLEN-1:0] dmem_wdata;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic                dmem_we;
  logic                halt;

  logic [31:0] imem [0:IMEM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  logic [31:0] rnd [0:3];
  logic [31:0] exp_addr [0:63];
  logic [31:0] exp_data [0:63];
  logic [31:0] last_fetch;  // Fetch address at the previous edge
  int          exp_count = 0;
  int          store_idx = 0;  // Stores seen so far
  int          cycles;

  function automatic logic [31:0] imm_op(input int f3, rd, rs1, imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] reg_op(input int f7, f3, rd, rs1, rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] lui(input int rd, imm);
    return {imm[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] auipc(input int rd, imm);
    return {imm[19:0], rd[4:0], 7'h17};
  endfunction

  // Loads and stores are always based on x0
  function automatic logic [31:0] lw(input int rd, off);
    return {off[11:0], 5'd0, 3'b010, rd[4:0], 7'h03};
  endfunction

  function automatic logic [31:0] sw(input int rs2, off);
    return {off[11:5], rs2[4:0], 5'd0, 3'b010, off[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] branch(input int f3, rs1, rs2, off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal(input int rd, off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6F};
  endfunction

  function automatic logic [31:0] jalr(input int rd, rs1, off);
    return {off[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h67};
  endfunction

`include "tb_program.svh"

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr[exp_count] = addr;
    exp_data[exp_count] = data;
    exp_count++;
  endtask

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  riscv_core dut (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata), .halt(halt)
  );

  // Combinational memories, word addressed
  assign imem_data  = imem[imem_addr[8:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[9:2]] <= dmem_wdata;
      store_idx <= store_idx + 1;
    end
  end

  always @(posedge clk) begin
    last_fetch <= imem_addr;
  end

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  a_reset_pc: assert property (@(posedge clk) rst |=> imem_addr == `RV_RESET_PC)
    else stop_with_failure($sformatf("** Error: imem_addr = %h after reset, expected %h",
                                     $sampled(imem_addr), `RV_RESET_PC));
  a_reset_halt: assert property (@(posedge clk) rst |=> !halt)
    else stop_with_failure($sformatf("** Error: halt = %h after reset, expected 0",
                                     $sampled(halt)));
  a_reset_no_store: assert property (@(posedge clk) rst |-> (!dmem_we ##1 !dmem_we))
    else stop_with_failure($sformatf("** Error: dmem_we = %h around reset, expected 0",
                                     $sampled(dmem_we)));

  a_store_expected: assert property (
    @(posedge clk) disable iff (rst) dmem_we |-> store_idx < exp_count
  ) else stop_with_failure("Store seen after the last expected store");
  a_store_addr: assert property (
    @(posedge clk) disable iff (rst)
    (dmem_we && store_idx < exp_count) |-> dmem_addr == exp_addr[store_idx]
  ) else stop_with_failure($sformatf("** Error: dmem_addr = %h, expected %h (store %0d)",
    $sampled(dmem_addr), exp_addr[$sampled(store_idx)], $sampled(store_idx)));
  a_store_data: assert property (
    @(posedge clk) disable iff (rst)
    (dmem_we && store_idx < exp_count) |-> dmem_wdata == exp_data[store_idx]
  ) else stop_with_failure($sformatf("** Error: dmem_wdata = %h, expected %h (store %0d)",
    $sampled(dmem_wdata), exp_data[$sampled(store_idx)], $sampled(store_idx)));

  // Frozen core after ECALL
  a_halt_no_store: assert property (@(posedge clk) disable iff (rst) halt |-> !dmem_we)
    else stop_with_failure($sformatf("** Error: dmem_we = %h while halted, expected 0",
                                     $sampled(dmem_we)));
  a_halt_pc_steady: assert property (
    @(posedge clk) disable iff (rst) halt |=> imem_addr == last_fetch
  ) else stop_with_failure($sformatf("** Error: imem_addr = %h while halted, expected %h",
                                     $sampled(imem_addr), $sampled(last_fetch)));

  initial begin
    void'($urandom(32'h48b805c6));
    rst = 1'b1;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = (i < PROG_WORDS) ? PROG_IMAGE[i] : ECALL;  // Runaway PC halts
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = 32'hD000_0000 ^ (32'(i) << 2);
    end
    for (int k = 0; k < 4; k++) begin
      rnd[k] = $urandom();
    end
    rnd[2] = rnd[2] | 32'h8000_0000;  // Negative operand for SRA
    for (int k = 0; k < 4; k++) begin
      dmem[RAND_INDEX + k] = rnd[k];
    end
    for (int k = 0; k < STORE_LOG_LEN; k++) begin
      expect_store(STORE_LOG[k][63:32], STORE_LOG[k][31:0]);
    end
    // Results of the load section, by the RV32I rules
    expect_store(32'h17C, rnd[0] + rnd[1]);
    expect_store(32'h180, rnd[0] - rnd[2]);
    expect_store(32'h184, rnd[1] ^ rnd[3]);
    // Vacated high bits fill with ones as rnd[2] is negative
    expect_store(32'h188, (rnd[2] >> rnd[3][4:0]) | ~(32'hFFFF_FFFF >> rnd[3][4:0]));
    expect_store(32'h18C, (rnd[0] < rnd[3]) ? 32'd1 : 32'd0);
    expect_store(32'h190, rnd[3]);

    repeat (5) @(negedge clk);
    rst = 1'b0;

    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      stop_with_failure("Timeout waiting for halt after ECALL");
    end else begin
      repeat (10) @(negedge clk);  // Core must stay frozen
      if (store_idx == exp_count) begin
        $display("Testbench passed");
        $finish;
      end else begin
        stop_with_failure($sformatf("Only %0d of %0d expected stores were seen",
                                    store_idx, exp_count));
      end
    end
  end

endmodule
